/* verilog.f */
+incdir+common
common/loadReturnPkg.sv
hdl/loadRequestCapture.sv
laneExtract/laneExtractor.sv
hdl/loadPacketAssembler.sv
hdl/loadReturnUnit.sv
verif/loadReturnUnit_checker.sv
verif/loadReturnUnit_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the load-return unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert \
	-f verilog.f \
	--top-module loadReturnUnit_tb \
	-o simv > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }

# Keep running past assertion errors so the testbench prints its summary
./obj_dir/simv +verilator+error+limit+100 > sim.log 2>&1

cat sim.log

grep -qx "sim passed" sim.log \
	&& { echo "Result: PASS"; exit 0; } \
	|| { echo "Result: FAIL"; exit 1; }

/* verif/loadReturnUnit_tb.sv */
`default_nettype none

`include "loadReturn_config.svh"

module loadReturnUnit_tb;

	import loadReturnPkg::*;

	localparam int testCount = 6;
	// The random test is the longest at about 80 cycles
	localparam int cyclesPerTest = 100;
	localparam int cycleLimit = testCount * cyclesPerTest;

	logic clk;
	logic reset;
	logic stall_i;
	logic loadValid_i;
	loadRequest_t loadReq_i;
	logic memReady_i;
	memLine_t memLine_i;
	logic busy_o;
	logic packetValid_o;
	loadPacket_t packet_o;

	integer seed;
	int cycleCount;
	int errors;
	int errorsAtStart;
	int testsFailed;
	int checkerFails;
	string testName;

	loadReturnUnit DUT (
		.clk(clk),
		.reset(reset),
		.stall_i(stall_i),
		.loadValid_i(loadValid_i),
		.loadReq_i(loadReq_i),
		.memReady_i(memReady_i),
		.memLine_i(memLine_i),
		.busy_o(busy_o),
		.packetValid_o(packetValid_o),
		.packet_o(packet_o)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	initial begin
		cycleCount = 0;
		while (cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout after %0d cycles, the tests did not finish", cycleCount);
		$display("sim failed");
		$finish;
	end

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// Byte k is {k, 15-k} mixed with a salt, unique per address
	function automatic memLine_t patternLine(input logic [3:0] salt);
		memLine_t line;
		for (int k = 0; k < `LR_LINE_BYTES; k++) begin
			line[8*k +: 8] = {4'(k), 4'(15 - k) ^ salt};
		end
		return line;
	endfunction

	function automatic loadPacket_t expectedPacket(input loadRequest_t req, input memLine_t line);
		loadPacket_t pkt;
		int byteIdx;
		pkt.warp = req.warp;
		pkt.laneMask = req.laneMask;
		for (int i = 0; i < `LR_NUM_LANES; i++) begin
			pkt.lanes[i].destReg = req.destReg;
			pkt.lanes[i].data = '0;
			if (req.laneMask[i]) begin
				for (int b = 0; b < `LR_DATA_W / 8; b++) begin
					byteIdx = int'(req.laneOffset[i]) + b;
					// Bytes past the line end stay zero
					if (byteIdx < `LR_LINE_BYTES) begin
						pkt.lanes[i].data[8*b +: 8] = line[8*byteIdx +: 8];
					end
				end
			end
		end
		return pkt;
	endfunction

	////////////////////////////////////////
	// Drive and check helpers
	////////////////////////////////////////

	task automatic waitCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic beginTest(input string name);
		testName = name;
		errorsAtStart = errors;
	endtask

	task automatic endTest();
		if (errors == errorsAtStart) begin
			$display("Test %s: ok", testName);
		end else begin
			testsFailed++;
			$display("Test %s: %0d errors", testName, errors - errorsAtStart);
		end
	endtask

	task automatic issueRequest(input loadRequest_t req);
		loadReq_i = req;
		loadValid_i = 1'b1;
		waitCycle();
		loadValid_i = 1'b0;
		assert (busy_o) else begin
			$display("Fail %0t: busy_o low after request accept", $time);
			errors++;
		end
	endtask

	task automatic returnLine(input memLine_t line, input int delay);
		repeat (delay) waitCycle();
		memLine_i = line;
		memReady_i = 1'b1;
		waitCycle();
		memReady_i = 1'b0;
	endtask

	task automatic awaitPacket();
		int waited;
		waited = 0;
		while (!packetValid_o && waited < 16) begin
			waitCycle();
			waited++;
		end
		assert (packetValid_o) else begin
			$display("No packet arrived within 16 cycles of the memory return");
			errors++;
		end
	endtask

	task automatic checkPacket(input loadPacket_t expected);
		assert (packetValid_o && packet_o === expected) else begin
			$display("Fail %0t: packet mismatch, expected %h got %h valid %b",
				$time, expected, packet_o, packetValid_o);
			errors++;
		end
	endtask

	task automatic expectNoPacket(input string where);
		assert (!packetValid_o) else begin
			$display("Fail %0t: unexpected packet valid %s", $time, where);
			errors++;
		end
	endtask

	task automatic runLoad(input loadRequest_t req, input memLine_t line, input int delay);
		issueRequest(req);
		returnLine(line, delay);
		awaitPacket();
		checkPacket(expectedPacket(req, line));
		waitCycle();
		expectNoPacket("after a one-cycle packet");
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic testReset();
		beginTest("reset");
		assert (!busy_o && !packetValid_o && packet_o == '0) else begin
			$display("Fail %0t: outputs not cleared by reset", $time);
			errors++;
		end
		endTest();
	endtask

	task automatic testFullMask();
		loadRequest_t req;
		memLine_t line;
		req.warp = 3'd6;
		req.destReg = 5'd21;
		req.laneMask = 8'hFF;
		req.laneOffset = {4'd3, 4'd15, 4'd13, 4'd12, 4'd7, 4'd1, 4'd4, 4'd0};
		line = patternLine(4'h0);
		beginTest("full mask");
		issueRequest(req);
		returnLine(line, 2);
		expectNoPacket("at the memory edge");
		waitCycle();
		expectNoPacket("one edge after the memory edge");
		waitCycle();
		checkPacket(expectedPacket(req, line));
		// Lane 6 reads the last byte only
		assert (packet_o.lanes[6].data == {24'h0, line[127:120]}) else begin
			$display("Fail %0t: lane 6 zero fill wrong, got %h", $time, packet_o.lanes[6].data);
			errors++;
		end
		waitCycle();
		expectNoPacket("after a one-cycle packet");
		endTest();
	endtask

	task automatic testPartialMask();
		loadRequest_t req;
		memLine_t line;
		req.warp = 3'd5;
		req.destReg = 5'd17;
		req.laneMask = 8'b1011_0010;
		req.laneOffset = {4'd14, 4'd2, 4'd9, 4'd0, 4'd15, 4'd6, 4'd11, 4'd5};
		line = patternLine(4'h3);
		beginTest("partial mask");
		issueRequest(req);
		returnLine(line, 1);
		awaitPacket();
		checkPacket(expectedPacket(req, line));
		assert (packet_o.warp == req.warp && packet_o.laneMask == req.laneMask) else begin
			$display("Fail %0t: warp or mask not echoed", $time);
			errors++;
		end
		for (int i = 0; i < `LR_NUM_LANES; i++) begin
			if (!req.laneMask[i]) begin
				assert (packet_o.lanes[i].data == '0 && packet_o.lanes[i].destReg == req.destReg)
				else begin
					$display("Fail %0t: inactive lane %0d wrong", $time, i);
					errors++;
				end
			end
		end
		waitCycle();
		expectNoPacket("after a one-cycle packet");
		endTest();
	endtask

	task automatic testBusyDrop();
		loadRequest_t reqA;
		loadRequest_t reqB;
		memLine_t line;
		reqA.warp = 3'd2;
		reqA.destReg = 5'd9;
		reqA.laneMask = 8'h5A;
		reqA.laneOffset = {4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8};
		reqB.warp = 3'd7;
		reqB.destReg = 5'd30;
		reqB.laneMask = 8'hFF;
		reqB.laneOffset = '0;
		line = patternLine(4'hC);
		beginTest("busy drop");
		// Memory return while idle must do nothing
		memLine_i = patternLine(4'h7);
		memReady_i = 1'b1;
		waitCycle();
		memReady_i = 1'b0;
		repeat (2) begin
			waitCycle();
			assert (!busy_o && !packetValid_o) else begin
				$display("Fail %0t: memory return while idle started the unit", $time);
				errors++;
			end
		end
		issueRequest(reqA);
		loadReq_i = reqB;
		loadValid_i = 1'b1;
		waitCycle();
		loadValid_i = 1'b0;
		returnLine(line, 1);
		awaitPacket();
		checkPacket(expectedPacket(reqA, line));
		repeat (8) begin
			waitCycle();
			assert (!packetValid_o && !busy_o) else begin
				$display("Fail %0t: request sent while busy was processed", $time);
				errors++;
			end
		end
		endTest();
	endtask

	task automatic testBackPressure();
		loadRequest_t reqA;
		loadRequest_t reqB;
		memLine_t lineA;
		memLine_t lineB;
		reqA.warp = 3'd1;
		reqA.destReg = 5'd4;
		reqA.laneMask = 8'hF0;
		reqA.laneOffset = {4'd0, 4'd13, 4'd2, 4'd14, 4'd4, 4'd15, 4'd6, 4'd12};
		reqB.warp = 3'd4;
		reqB.destReg = 5'd27;
		reqB.laneMask = 8'h3C;
		reqB.laneOffset = {4'd9, 4'd8, 4'd7, 4'd6, 4'd5, 4'd4, 4'd3, 4'd2};
		lineA = patternLine(4'h6);
		lineB = patternLine(4'h9);
		beginTest("back-pressure");
		stall_i = 1'b1;
		issueRequest(reqA);
		returnLine(lineA, 1);
		awaitPacket();
		checkPacket(expectedPacket(reqA, lineA));
		issueRequest(reqB);
		returnLine(lineB, 1);
		repeat (6) begin
			waitCycle();
			checkPacket(expectedPacket(reqA, lineA));
		end
		assert (busy_o) else begin
			$display("Fail %0t: second request not waiting for the output", $time);
			errors++;
		end
		// First packet is taken at the next edge and the second loads behind it
		stall_i = 1'b0;
		waitCycle();
		checkPacket(expectedPacket(reqB, lineB));
		waitCycle();
		expectNoPacket("after the second packet");
		endTest();
	endtask

	task automatic testRandom();
		loadRequest_t req;
		memLine_t line;
		logic [31:0] rnd;
		beginTest("random");
		for (int n = 0; n < 10; n++) begin
			rnd = $random(seed);
			req.warp = rnd[2:0];
			req.destReg = rnd[7:3];
			req.laneMask = rnd[15:8];
			req.laneOffset = $random(seed);
			for (int w = 0; w < 4; w++) begin
				line[32*w +: 32] = $random(seed);
			end
			runLoad(req, line, int'(rnd[17:16]));
		end
		endTest();
	endtask

	initial begin
		seed = 20016;
		errors = 0;
		testsFailed = 0;
		reset = 1'b1;
		stall_i = 1'b0;
		loadValid_i = 1'b0;
		loadReq_i = '0;
		memReady_i = 1'b0;
		memLine_i = '0;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		testReset();
		testFullMask();
		testPartialMask();
		testBusyDrop();
		testBackPressure();
		testRandom();
		checkerFails = DUT.unitChecker.resetFails + DUT.unitChecker.holdFails
			+ DUT.unitChecker.laneFails;
		$display("Summary: %0d of %0d tests failed, %0d check errors, %0d assertion failures",
			testsFailed, testCount, errors, checkerFails);
		if (errors == 0 && checkerFails == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/loadReturnUnit_checker.sv */
`default_nettype none

`include "loadReturn_config.svh"

module loadReturnUnit_checker (
	input logic clk,
	input logic reset,
	input logic stall_i,
	input logic busy_i,
	input logic packetValid_i,
	input loadReturnPkg::loadPacket_t packet_i
);

	import loadReturnPkg::*;

	int resetFails = 0;
	int holdFails = 0;
	int laneFails = 0;

	laneMask_t laneHasData;

	always_comb begin
		for (int i = 0; i < `LR_NUM_LANES; i++) begin
			laneHasData[i] = |packet_i.lanes[i].data;
		end
	end

	////////////////////////////////////////
	// Output protocol
	////////////////////////////////////////

	assert property (@(posedge clk) reset |=> (!busy_i && !packetValid_i))
	else begin
		resetFails++;
		$error("busy or packet valid high in the cycle after reset");
	end

	// A stalled packet must not move
	assert property (@(posedge clk) disable iff (reset)
		(packetValid_i && stall_i) |=> (packetValid_i && $stable(packet_i)))
	else begin
		holdFails++;
		$error("packet changed or dropped while stalled");
	end

	assert property (@(posedge clk) disable iff (reset)
		packetValid_i |-> ((laneHasData & ~packet_i.laneMask) == '0))
	else begin
		laneFails++;
		$error("inactive lane carries nonzero data");
	end

endmodule

bind loadReturnUnit loadReturnUnit_checker unitChecker (
	.clk(clk),
	.reset(reset),
	.stall_i(stall_i),
	.busy_i(busy_o),
	.packetValid_i(packetValid_o),
	.packet_i(packet_o)
);

`default_nettype wire

/* hdl/loadReturnUnit.sv */
`default_nettype none

`include "loadReturn_config.svh"

module loadReturnUnit (
	input logic clk,
	input logic reset,
	input logic stall_i,

	// Warp load request
	input logic loadValid_i,
	input loadReturnPkg::loadRequest_t loadReq_i,

	// Memory read return
	input logic memReady_i,
	input loadReturnPkg::memLine_t memLine_i,

	output logic busy_o,
	output logic packetValid_o,
	output loadReturnPkg::loadPacket_t packet_o
);

	import loadReturnPkg::*;

	logic laneLoad;
	logic packetLoad;
	logic outputReady;
	loadRequest_t heldReq;
	memLine_t heldLine;
	lanePacket_t [`LR_NUM_LANES-1:0] lanes;

	////////////////////////////////////////
	// Request and memory control
	////////////////////////////////////////

	loadRequestCapture requestCapture (
		.clk(clk),
		.reset(reset),
		.loadValid_i(loadValid_i),
		.loadReq_i(loadReq_i),
		.memReady_i(memReady_i),
		.memLine_i(memLine_i),
		.outputReady_i(outputReady),
		.busy_o(busy_o),
		.laneLoad_o(laneLoad),
		.packetLoad_o(packetLoad),
		.heldReq_o(heldReq),
		.heldLine_o(heldLine)
	);

	////////////////////////////////////////
	// Per-lane extraction, all lanes at once
	////////////////////////////////////////

	for (genvar i = 0; i < `LR_NUM_LANES; i++) begin : gLane
		laneExtractor extractor (
			.clk(clk),
			.reset(reset),
			.laneLoad_i(laneLoad),
			.line_i(heldLine),
			.offset_i(heldReq.laneOffset[i]),
			.active_i(heldReq.laneMask[i]),
			.destReg_i(heldReq.destReg),
			.lane_o(lanes[i])
		);
	end

	////////////////////////////////////////
	// Output stage
	////////////////////////////////////////

	loadPacketAssembler packetAssembler (
		.clk(clk),
		.reset(reset),
		.stall_i(stall_i),
		.packetLoad_i(packetLoad),
		.lanes_i(lanes),
		.req_i(heldReq),
		.outputReady_o(outputReady),
		.packetValid_o(packetValid_o),
		.packet_o(packet_o)
	);

endmodule

`default_nettype wire

/* hdl/loadPacketAssembler.sv */
`default_nettype none

`include "loadReturn_config.svh"

module loadPacketAssembler (
	input logic clk,
	input logic reset,
	input logic stall_i,
	input logic packetLoad_i,
	input loadReturnPkg::lanePacket_t [`LR_NUM_LANES-1:0] lanes_i,
	input loadReturnPkg::loadRequest_t req_i,
	output logic outputReady_o,
	output logic packetValid_o,
	output loadReturnPkg::loadPacket_t packet_o
);

	////////////////////////////////////////
	// Output packet register
	////////////////////////////////////////

	// packetLoad_i only arrives with outputReady_o high, so a held packet is never overwritten
	always_ff @(posedge clk) begin
		if (reset) begin
			packet_o <= '0;
		end else if (packetLoad_i) begin
			packet_o.warp <= req_i.warp;
			packet_o.laneMask <= req_i.laneMask;
			packet_o.lanes <= lanes_i;
		end
	end

	////////////////////////////////////////
	// Valid flag and back-pressure
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			packetValid_o <= 1'b0;
		end else if (packetLoad_i) begin
			packetValid_o <= 1'b1;
		end else if (!stall_i) begin
			// Consumed on the first edge without stall
			packetValid_o <= 1'b0;
		end
	end

	// Empty now, or emptied at this edge
	assign outputReady_o = !packetValid_o || !stall_i;

endmodule

`default_nettype wire

/* laneExtract/laneExtractor.sv */
`default_nettype none

`include "loadReturn_config.svh"

module laneExtractor (
	input logic clk,
	input logic reset,
	input logic laneLoad_i,
	input loadReturnPkg::memLine_t line_i,
	input loadReturnPkg::laneOffset_t offset_i,
	input logic active_i,
	input logic [`LR_REG_W-1:0] destReg_i,
	output loadReturnPkg::lanePacket_t lane_o
);

	import loadReturnPkg::*;

	logic [`LR_DATA_W-1:0] word;
	lanePacket_t laneNext;

	////////////////////////////////////////
	// Byte gather
	////////////////////////////////////////

	// Lowest addressed byte ends up least significant
	for (genvar k = 0; k < `LR_DATA_W / 8; k++) begin : gByte
		logic [`LR_OFFSET_W:0] byteIdx;

		assign byteIdx = {1'b0, offset_i} + (`LR_OFFSET_W + 1)'(k);

		// The line is a power of two bytes, so the carry bit marks a byte past the end
		assign word[8*k +: 8] = byteIdx[`LR_OFFSET_W]
			? 8'h00
			: line_i[{byteIdx[`LR_OFFSET_W-1:0], 3'b000} +: 8];
	end

	////////////////////////////////////////
	// Lane packet register
	////////////////////////////////////////

	always_comb begin
		// Inactive lane returns zero but still names its register
		laneNext.data = active_i ? word : '0;
		laneNext.destReg = destReg_i;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			lane_o <= '0;
		end else if (laneLoad_i) begin
			lane_o <= laneNext;
		end
	end

endmodule

`default_nettype wire

/* hdl/loadRequestCapture.sv */
`default_nettype none

module loadRequestCapture (
	input logic clk,
	input logic reset,

	// Request side
	input logic loadValid_i,
	input loadReturnPkg::loadRequest_t loadReq_i,

	// Memory side
	input logic memReady_i,
	input loadReturnPkg::memLine_t memLine_i,

	// From the output stage
	input logic outputReady_i,

	output logic busy_o,
	output logic laneLoad_o,
	output logic packetLoad_o,
	output loadReturnPkg::loadRequest_t heldReq_o,
	output loadReturnPkg::memLine_t heldLine_o
);

	////////////////////////////////////////
	// FSM state
	////////////////////////////////////////

	typedef enum logic [1:0] {
		idle,
		waitMem,
		extract,
		assemble
	} captureState_t;

	captureState_t state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
		end else begin
			case (state)
				idle: begin
					if (loadValid_i) begin
						state <= waitMem;
					end
				end
				waitMem: begin
					if (memReady_i) begin
						state <= extract;
					end
				end
				// Lanes register their words on this edge
				extract: begin
					state <= assemble;
				end
				// Wait here until the output register can take the packet
				assemble: begin
					if (outputReady_i) begin
						state <= idle;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Request and line holding registers
	////////////////////////////////////////

	// Request is only taken when idle, so a request seen while busy is lost
	always_ff @(posedge clk) begin
		if (reset) begin
			heldReq_o <= '0;
		end else if (state == idle && loadValid_i) begin
			heldReq_o <= loadReq_i;
		end
	end

	// memReady_i outside waitMem is ignored
	always_ff @(posedge clk) begin
		if (reset) begin
			heldLine_o <= '0;
		end else if (state == waitMem && memReady_i) begin
			heldLine_o <= memLine_i;
		end
	end

	////////////////////////////////////////
	// Strobes
	////////////////////////////////////////

	assign laneLoad_o = (state == extract);

	// Handoff edge to the output stage
	assign packetLoad_o = (state == assemble) && outputReady_i;

	assign busy_o = (state != idle);

endmodule

`default_nettype wire

/* common/loadReturnPkg.sv */
`default_nettype none

`include "loadReturn_config.svh"

package loadReturnPkg;

	////////////////////////////////////////
	// Scalar types
	////////////////////////////////////////

	// Byte offset of a lane's word within the line
	typedef logic [`LR_OFFSET_W-1:0] laneOffset_t;

	// One bit per lane, bit i is lane i
	typedef logic [`LR_NUM_LANES-1:0] laneMask_t;

	// Byte k sits at bits 8k+7 down to 8k
	typedef logic [`LR_LINE_BYTES*8-1:0] memLine_t;

	////////////////////////////////////////
	// Request and packet structs
	////////////////////////////////////////

	// Warp load request as issued by the load/store stage
	typedef struct packed {
		logic [`LR_WARP_W-1:0] warp;
		logic [`LR_REG_W-1:0] destReg;
		laneMask_t laneMask;
		laneOffset_t [`LR_NUM_LANES-1:0] laneOffset;
	} loadRequest_t;

	// Data word and its writeback register for one lane
	typedef struct packed {
		logic [`LR_DATA_W-1:0] data;
		logic [`LR_REG_W-1:0] destReg;
	} lanePacket_t;

	// Whole warp result handed to writeback
	typedef struct packed {
		logic [`LR_WARP_W-1:0] warp;
		laneMask_t laneMask;
		lanePacket_t [`LR_NUM_LANES-1:0] lanes;
	} loadPacket_t;

endpackage

`default_nettype wire

/* common/loadReturn_config.svh */
`ifndef LOADRETURN_CONFIG_SVH
`define LOADRETURN_CONFIG_SVH

////////////////////////////////////////
// Warp geometry
////////////////////////////////////////

// Lanes per warp
`define LR_NUM_LANES 8

// Warp index width
`define LR_WARP_W 3

// Destination register index width
`define LR_REG_W 5

////////////////////////////////////////
// Memory line and lane data
////////////////////////////////////////

// Bytes per memory read line
`define LR_LINE_BYTES 16

// Byte offset into the line, log2 of LR_LINE_BYTES
`define LR_OFFSET_W 4

// Lane data word width
`define LR_DATA_W 32

`endif
